//--- all.f
gpcPkg.sv
gpcIfs.sv
threadFetch.sv
decodeRegs.sv
aluUnit.sv
branchUnit.sv
writebackStage.sv
gpcCore.sv
tbChecker.sv
tbGpc.sv

//--- aluUnit.sv
/* Q102H operand select and ALU
   Serves OP and OP-IMM, and forms the store address */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    execIf.dst              exec,
    output gpcPkg::wordT    aluResult
);

    gpcPkg::wordT  iImmQ102H;
    gpcPkg::wordT  sImmQ102H;
    gpcPkg::wordT  opAQ102H;
    gpcPkg::wordT  opBQ102H;
    logic [6:0]    opcodeQ102H;
    logic [2:0]    funct3Q102H;
    logic [3:0]    codeQ102H;
    gpcPkg::aluOpT aluOpQ102H;
    logic [4:0]    shamtQ102H;

    assign opcodeQ102H = exec.inst[6:0];
    assign funct3Q102H = exec.inst[14:12];

    // Immediates
    assign iImmQ102H = {{20{exec.inst[31]}}, exec.inst[31:20]};
    assign sImmQ102H = {{20{exec.inst[31]}}, exec.inst[31:25], exec.inst[11:7]};

    assign opAQ102H = exec.rs1Data;
    assign opBQ102H = exec.store  ? sImmQ102H :
                      exec.immSel ? iImmQ102H : exec.rs2Data;
    assign shamtQ102H = opBQ102H[4:0];

    // ALU code from funct3 and funct7[5]
    always_comb begin
        codeQ102H = {1'b0, funct3Q102H};
        if ((opcodeQ102H == gpcPkg::OP_OP) ||
            ((opcodeQ102H == gpcPkg::OP_OPIMM) && (funct3Q102H[1:0] == 2'b01))) begin
            codeQ102H[3] = exec.inst[30];   // SUB or SRA
        end
        if (exec.store) codeQ102H = gpcPkg::ADD;   // Address add
    end

    assign aluOpQ102H = gpcPkg::aluOpT'(codeQ102H);

    always_comb begin
        case (aluOpQ102H)
            gpcPkg::ADD  : aluResult = opAQ102H + opBQ102H;
            gpcPkg::SUB  : aluResult = opAQ102H - opBQ102H;
            gpcPkg::SLL  : aluResult = opAQ102H << shamtQ102H;
            gpcPkg::SLT  : aluResult = {31'b0, $signed(opAQ102H) < $signed(opBQ102H)};
            gpcPkg::SLTU : aluResult = {31'b0, opAQ102H < opBQ102H};
            gpcPkg::XOR  : aluResult = opAQ102H ^ opBQ102H;
            gpcPkg::SRL  : aluResult = opAQ102H >> shamtQ102H;
            gpcPkg::SRA  : aluResult = $signed(opAQ102H) >>> shamtQ102H;
            gpcPkg::OR   : aluResult = opAQ102H | opBQ102H;
            gpcPkg::AND  : aluResult = opAQ102H & opBQ102H;
            default      : aluResult = '0;   // Unused funct7 combos
        endcase
    end

endmodule

`default_nettype wire

//--- branchUnit.sv
/* Q102H branch comparator and next-PC select
   Covers the six conditional branches and JAL */
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
    execIf.dst              exec,
    output gpcPkg::wordT    nextPc,
    output gpcPkg::wordT    linkPc
);

    gpcPkg::wordT bImmQ102H;
    gpcPkg::wordT jImmQ102H;
    logic         condQ102H;
    logic         takenQ102H;

    assign bImmQ102H = {{20{exec.inst[31]}}, exec.inst[7], exec.inst[30:25],
                        exec.inst[11:8], 1'b0};
    assign jImmQ102H = {{12{exec.inst[31]}}, exec.inst[19:12], exec.inst[20],
                        exec.inst[30:21], 1'b0};

    // Condition on funct3, rs1 against rs2
    always_comb begin
        case (exec.inst[14:12])
            3'b000  : condQ102H = (exec.rs1Data == exec.rs2Data);                    // BEQ
            3'b001  : condQ102H = (exec.rs1Data != exec.rs2Data);                    // BNE
            3'b100  : condQ102H = ($signed(exec.rs1Data) <  $signed(exec.rs2Data));  // BLT
            3'b101  : condQ102H = ($signed(exec.rs1Data) >= $signed(exec.rs2Data));  // BGE
            3'b110  : condQ102H = (exec.rs1Data <  exec.rs2Data);                    // BLTU
            3'b111  : condQ102H = (exec.rs1Data >= exec.rs2Data);                    // BGEU
            default : condQ102H = 1'b0;
        endcase
    end

    assign takenQ102H = exec.branch && condQ102H;
    assign linkPc     = exec.pc + 32'd4;

    assign nextPc = takenQ102H ? exec.pc + bImmQ102H :
                    exec.jal   ? exec.pc + jImmQ102H : linkPc;   // Sequential by default

endmodule

`default_nettype wire

//--- decodeRegs.sv
/* Q101H decode and per-thread register files
   Reads operands for the thread in Q101H and registers the Q102H bundle */
`timescale 1ns/1ps
`default_nettype none

module decodeRegs (
    input  wire logic           QClk,
    input  wire logic           arstN,
    input  gpcPkg::instT        instFetch,    // Arrives in Q101H
    input  gpcPkg::wordT        pc,           // Q100H fetch PC
    input  gpcPkg::threadT      thread,       // Q100H ring
    execIf.src                  exec,
    wbIf.dst                    wb,
    output gpcPkg::threadT      pcEnThread
);

    gpcPkg::wordT   regFile [gpcPkg::NUM_THREADS][gpcPkg::NUM_REGS];
    gpcPkg::wordT   pcQ101H;
    gpcPkg::threadT threadQ101H;
    gpcPkg::wordT   rs1DataQ101H;
    gpcPkg::wordT   rs2DataQ101H;
    gpcPkg::regPtrT rs1PtrQ101H;
    gpcPkg::regPtrT rs2PtrQ101H;
    logic [6:0]     opcodeQ101H;
    logic           validQ101H;

    // Q100H to Q101H
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) threadQ101H <= '0;   // Empty slot until the ring reaches Q101H
        else        threadQ101H <= thread;
    end

    always_ff @(posedge QClk) pcQ101H <= pc;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////
    assign opcodeQ101H = instFetch[6:0];
    assign rs1PtrQ101H = instFetch[18:15];   // Bit 19 dropped
    assign rs2PtrQ101H = instFetch[23:20];   // Bit 24 dropped
    assign validQ101H  = |threadQ101H;

    // Operand read from the thread in Q101H
    always_comb begin
        rs1DataQ101H = '0;
        rs2DataQ101H = '0;
        for (int t = 0; t < gpcPkg::NUM_THREADS; t++) begin
            if (threadQ101H[t]) begin
                rs1DataQ101H |= regFile[t][rs1PtrQ101H];
                rs2DataQ101H |= regFile[t][rs2PtrQ101H];
            end
        end
    end

    // Q101H to Q102H control
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            exec.immSel <= 1'b0;
            exec.branch <= 1'b0;
            exec.jal    <= 1'b0;
            exec.store  <= 1'b0;
            exec.regWr  <= 1'b0;
            exec.thread <= '0;
        end else begin
            exec.immSel <= (opcodeQ101H == gpcPkg::OP_OPIMM);
            exec.branch <= (opcodeQ101H == gpcPkg::OP_BRANCH);
            exec.jal    <= (opcodeQ101H == gpcPkg::OP_JAL);
            exec.store  <= (opcodeQ101H == gpcPkg::OP_STORE) && validQ101H;
            exec.regWr  <= validQ101H && ((opcodeQ101H == gpcPkg::OP_OP)    ||
                                          (opcodeQ101H == gpcPkg::OP_OPIMM) ||
                                          (opcodeQ101H == gpcPkg::OP_JAL));
            exec.thread <= threadQ101H;
        end
    end

    // Q101H to Q102H payload
    always_ff @(posedge QClk) begin
        exec.inst    <= instFetch;
        exec.pc      <= pcQ101H;
        exec.rs1Data <= rs1DataQ101H;
        exec.rs2Data <= rs2DataQ101H;
    end

    assign pcEnThread = exec.thread;   // Q102H owner takes nextPc

    //////////////////////////////////////////////////////////////////////
    // Q104H register write
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            for (int t = 0; t < gpcPkg::NUM_THREADS; t++) begin
                for (int r = 0; r < gpcPkg::NUM_REGS; r++) begin
                    regFile[t][r] <= '0;
                end
            end
        end else if (wb.wrEn && (wb.ptr != '0)) begin   // x0 stays zero
            for (int t = 0; t < gpcPkg::NUM_THREADS; t++) begin
                if (wb.thread[t]) regFile[t][wb.ptr] <= wb.data;
            end
        end
    end

    wbThreadLive: assert property (@(posedge QClk) disable iff (!arstN)
                                   wb.wrEn |-> (wb.thread != '0))
        else $error("register write with no thread selected");

endmodule

`default_nettype wire

//--- gpcCore.sv
/* Four-thread barrel RV32I core top level
   Fetch, decode, execute and writeback units around two internal bundles */
`timescale 1ns/1ps
`default_nettype none

module gpcCore (
    input  wire logic       QClk,
    input  wire logic       arstN,
    input  gpcPkg::instT    instFetch,   // Registered memory, one cycle after pc
    output gpcPkg::wordT    pc,
    output gpcPkg::wordT    memAdrs,
    output gpcPkg::wordT    memWrData,
    output logic            memWr
);

    gpcPkg::wordT   nextPc;
    gpcPkg::wordT   linkPc;
    gpcPkg::wordT   aluResult;
    gpcPkg::threadT pcEnThread;
    gpcPkg::threadT threadQ100H;

    execIf execQ102H ();
    wbIf   wbQ104H ();

    threadFetch uFetch (
        .QClk       (QClk),
        .arstN      (arstN),
        .nextPc     (nextPc),
        .pcEnThread (pcEnThread),
        .pc         (pc),
        .thread     (threadQ100H)
    );

    decodeRegs uDecode (
        .QClk       (QClk),
        .arstN      (arstN),
        .instFetch  (instFetch),
        .pc         (pc),
        .thread     (threadQ100H),
        .exec       (execQ102H.src),
        .wb         (wbQ104H.dst),
        .pcEnThread (pcEnThread)
    );

    aluUnit uAlu (
        .exec      (execQ102H.dst),
        .aluResult (aluResult)
    );

    branchUnit uBranch (
        .exec   (execQ102H.dst),
        .nextPc (nextPc),
        .linkPc (linkPc)
    );

    writebackStage uWb (
        .QClk      (QClk),
        .arstN     (arstN),
        .exec      (execQ102H.dst),
        .aluResult (aluResult),
        .linkPc    (linkPc),
        .wb        (wbQ104H.src),
        .memAdrs   (memAdrs),
        .memWrData (memWrData),
        .memWr     (memWr)
    );

endmodule

`default_nettype wire

//--- gpcIfs.sv
/* Core-internal bundles
   Decode-to-execute values in Q102H and the Q104H register write */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Q102H bundle from decode
//////////////////////////////////////////////////////////////////////
interface execIf;
    gpcPkg::instT   inst;      // Instruction in Q102H
    gpcPkg::wordT   pc;
    gpcPkg::wordT   rs1Data;
    gpcPkg::wordT   rs2Data;
    logic           immSel;    // OP-IMM uses I immediate
    logic           branch;
    logic           jal;
    logic           store;
    logic           regWr;
    gpcPkg::threadT thread;    // Thread owning this slot

    modport src (output inst, pc, rs1Data, rs2Data, immSel, branch, jal, store,
                 regWr, thread);
    modport dst (input  inst, pc, rs1Data, rs2Data, immSel, branch, jal, store,
                 regWr, thread);
endinterface

//////////////////////////////////////////////////////////////////////
// Q104H register write
//////////////////////////////////////////////////////////////////////
interface wbIf;
    logic           wrEn;
    gpcPkg::threadT thread;
    gpcPkg::regPtrT ptr;
    gpcPkg::wordT   data;

    modport src (output wrEn, thread, ptr, data);
    modport dst (input  wrEn, thread, ptr, data);
endinterface

`default_nettype wire

//--- gpcPkg.sv
/* Four-thread barrel RV32I core shared definitions
   Widths, opcodes, ALU operation codes and common vector types */
`default_nettype none

package gpcPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN        = 32;   // Data and address width
    localparam int NUM_THREADS = 4;    // Barrel depth
    localparam int NUM_REGS    = 16;   // Registers per thread

    typedef logic [XLEN-1:0]             wordT;
    typedef logic [NUM_THREADS-1:0]      threadT;   // One-hot thread select
    typedef logic [$clog2(NUM_REGS)-1:0] regPtrT;   // Low bits of a 5-bit field
    typedef logic [31:0]                 instT;

    //////////////////////////////////////////////////////////////////////
    // RV32I opcodes kept by this core
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    // ALU code is {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } aluOpT;

    localparam threadT THREAD_RESET = 4'b0001;   // Thread 0 fetches first

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the barrel core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tbGpc -o simGpc
./obj_dir/simGpc | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

//--- tbChecker.sv
/* Store monitor for the barrel core testbench
   Checks outputs around reset and every memWr strobe against the expected list */
`timescale 1ns/1ps
`default_nettype none

module tbChecker #(
    parameter int EXP_MAX = 128
) (
    input  wire logic         QClk,
    input  wire logic         arstN,
    input  wire gpcPkg::wordT pc,
    input  wire gpcPkg::wordT memAdrs,
    input  wire gpcPkg::wordT memWrData,
    input  wire logic         memWr,
    input  wire gpcPkg::wordT parkPc,              // Address of the closing JAL loop
    input  wire gpcPkg::wordT expAdrs [EXP_MAX],   // Four copies per store
    input  wire gpcPkg::wordT expData [EXP_MAX],
    input  var  int           expLen,
    output logic              done,
    output int                seenCount,
    output int                passCount,
    output int                failCount
);

    int   seenN   = 0;
    int   passN   = 0;
    int   failN   = 0;
    int   parkN   = 0;      // Back-to-back fetches of the park loop
    logic resetOk = 1'b0;   // Reset test finished
    logic resetBad = 1'b0;  // Activity seen while in reset

    assign seenCount = seenN;
    assign passCount = passN;
    assign failCount = failN;

    // All stores seen and every thread spinning on the final JAL
    assign done      = resetOk && (expLen > 0) && (seenN >= expLen) &&
                       (parkN >= gpcPkg::NUM_THREADS);

    // Sampled mid-cycle, away from the driving edge
    always @(negedge QClk) begin
        if (!arstN) begin
            if (memWr || pc != '0) resetBad = 1'b1;
        end else if (!resetOk) begin
            resetOk = 1'b1;   // First cycle out of reset, thread 0 at address 0
            if (resetBad || memWr || pc != '0) begin
                $display("error at %0d ns: memWr or pc active during or just after reset",
                         $time);
                failN++;
            end else begin
                $display("reset test passed, pc %h memWr %b", pc, memWr);
                passN++;
            end
        end else begin
            if (memWr) begin
                if (seenN >= expLen) begin
                    $display("extra store of %h to address %h after all expected stores",
                             memWrData, memAdrs);
                    failN++;
                end else if (memAdrs == expAdrs[seenN] && memWrData == expData[seenN]) begin
                    $display("store %0d from thread %0d passed, %h to address %h",
                             seenN, seenN % 4, memWrData, memAdrs);
                    passN++;
                end else begin
                    $display("error at %0d ns: store %0d wrote %h to %h, expected %h to %h",
                             $time, seenN, memWrData, memAdrs, expData[seenN],
                             expAdrs[seenN]);
                    failN++;
                end
                seenN++;
            end
            if (pc == parkPc) parkN++;
            else              parkN = 0;
        end
    end

endmodule

`default_nettype wire

//--- tbGpc.sv
/* Barrel core testbench top
   Builds the program table, models instruction memory and bounds the run */
`timescale 1ns/1ps
`default_nettype none

module tbGpc;

    localparam int PROG_MAX = 64;    // Words of instruction memory
    localparam int EXP_MAX  = 128;   // Expected store slots

    // {funct7[5], funct3} of ADD SUB AND OR XOR SLL SRL SRA SLT SLTU
    localparam logic [3:0] OP_TABLE [10] = '{4'b0000, 4'b1000, 4'b0111, 4'b0110, 4'b0100,
                                             4'b0001, 4'b0101, 4'b1101, 4'b0010, 4'b0011};

    logic         QClk;
    logic         arstN;
    gpcPkg::instT instFetch;
    gpcPkg::wordT pc;
    gpcPkg::wordT memAdrs;
    gpcPkg::wordT memWrData;
    logic         memWr;

    gpcPkg::instT progInst [PROG_MAX];
    gpcPkg::wordT expAdrs [EXP_MAX];
    gpcPkg::wordT expData [EXP_MAX];
    gpcPkg::wordT shadow [32];       // Architectural registers of one thread
    gpcPkg::wordT parkPc;            // Final JAL-to-self
    int           progLen;
    int           expLen;
    int           skipLeft;          // Entries hopped over by a taken branch or jump
    int           cycles = 0;
    int           limit;
    int           passCount;
    int           failCount;
    int           seenCount;
    logic         done;

    gpcCore dut (
        .QClk      (QClk),
        .arstN     (arstN),
        .instFetch (instFetch),
        .pc        (pc),
        .memAdrs   (memAdrs),
        .memWrData (memWrData),
        .memWr     (memWr)
    );

    tbChecker #(.EXP_MAX(EXP_MAX)) chk (
        .QClk      (QClk),
        .arstN     (arstN),
        .pc        (pc),
        .memAdrs   (memAdrs),
        .memWrData (memWrData),
        .memWr     (memWr),
        .parkPc    (parkPc),
        .expAdrs   (expAdrs),
        .expData   (expData),
        .expLen    (expLen),
        .done      (done),
        .seenCount (seenCount),
        .passCount (passCount),
        .failCount (failCount)
    );

    always #10 QClk = ~QClk;   // 20 ns period

    always @(posedge QClk) cycles <= cycles + 1;

    // Registered instruction memory, one cycle behind pc
    always @(posedge QClk) begin
        instFetch <= progInst[pc[7:2]];
    end

    //////////////////////////////////////////////////////////////////////
    // RV32I reference results
    //////////////////////////////////////////////////////////////////////
    function automatic gpcPkg::wordT refAlu(input logic [3:0] code, input gpcPkg::wordT a,
                                            input gpcPkg::wordT b);
        case (code)
            4'b0000 : return a + b;
            4'b1000 : return a - b;
            4'b0001 : return a << b[4:0];
            4'b0010 : return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'b0011 : return (a < b) ? 32'd1 : 32'd0;
            4'b0100 : return a ^ b;
            4'b0101 : return a >> b[4:0];
            4'b1101 : return $signed(a) >>> b[4:0];   // Sign fill
            4'b0110 : return a | b;
            default : return a & b;
        endcase
    endfunction

    task automatic emitInst(input gpcPkg::instT inst, output logic live);
        progInst[progLen] = inst;
        progLen++;
        live = (skipLeft == 0);
        if (!live) skipLeft--;
    endtask

    task automatic addImm(input int rd, input int rs1, input int imm);
        logic live;
        emitInst({12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011}, live);   // ADDI
        if (live && rd != 0) shadow[rd] = shadow[rs1] + gpcPkg::wordT'(imm);
    endtask

    task automatic aluReg(input logic [3:0] code, input int rd, input int rs1, input int rs2);
        logic live;
        emitInst({1'b0, code[3], 5'b0, 5'(rs2), 5'(rs1), code[2:0], 5'(rd), 7'b0110011}, live);
        if (live && rd != 0) shadow[rd] = refAlu(code, shadow[rs1], shadow[rs2]);
    endtask

    task automatic storeWord(input int rs2, input int rs1, input int off);
        logic        live;
        logic [11:0] imm;
        imm = 12'(off);
        emitInst({imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011}, live);
        if (live) begin
            repeat (4) begin   // One per thread, back to back
                expAdrs[expLen] = shadow[rs1] + gpcPkg::wordT'(off);
                expData[expLen] = shadow[rs2];
                expLen++;
            end
        end
    endtask

    // BEQ or BNE hopping over skip entries when taken
    task automatic branchIf(input logic [2:0] f3, input int rs1, input int rs2, input int skip);
        logic        live;
        logic [12:0] off;
        off = 13'(4 * (skip + 1));
        emitInst({off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011},
                 live);
        if (live && ((shadow[rs1] == shadow[rs2]) == (f3 == 3'b000))) skipLeft = skip;
    endtask

    task automatic jumpLink(input int rd, input int skip);
        logic         live;
        logic [20:0]  off;
        gpcPkg::wordT here;
        off  = 21'(4 * (skip + 1));
        here = gpcPkg::wordT'(4 * progLen);
        emitInst({off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111}, live);
        if (live) begin
            if (rd != 0) shadow[rd] = here + 32'd4;   // Link value
            skipLeft = skip;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program, reset and run control
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic        live;
        QClk      = 1'b0;
        arstN     = 1'b0;
        instFetch = '0;
        progLen   = 0;
        expLen    = 0;
        skipLeft  = 0;
        for (int i = 0; i < PROG_MAX; i++) progInst[i] = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        void'($urandom(32'hf5dd));
        r1 = $urandom;
        r2 = $urandom;

        addImm(1, 0, int'({{20{r1[11]}}, r1[11:0]}));   // Random 12-bit operands
        addImm(2, 0, int'({{20{r2[11]}}, r2[11:0]}));
        storeWord(1, 0, 'h100);
        storeWord(2, 0, 'h104);
        for (int i = 0; i < 10; i++) begin
            aluReg(OP_TABLE[i], 3, 1, 2);
            storeWord(3, 0, 'h110 + 4 * i);
        end
        branchIf(3'b000, 1, 1, 1);   // Taken BEQ
        storeWord(1, 0, 'h1f0);      // Never stored
        branchIf(3'b001, 2, 2, 1);   // BNE falls through
        storeWord(2, 0, 'h1f4);
        jumpLink(5, 1);
        storeWord(1, 0, 'h1f8);      // Jumped over
        storeWord(5, 0, 'h1fc);
        addImm(0, 1, 5);             // x0 keeps zero
        storeWord(0, 0, 'h200);
        parkPc = gpcPkg::wordT'(4 * progLen);
        emitInst(32'h0000_006f, live);   // JAL x0, 0 parks each thread

        limit = progLen * 4 + 40;
        repeat (2) @(posedge QClk);
        arstN <= 1'b1;
        while (!done && cycles < limit) @(posedge QClk);
        if (!done) begin
            $display("timeout after %0d cycles, %0d of %0d stores seen, threads not all parked",
                     cycles, seenCount, expLen);
        end
        $display("%0d checks passed, %0d checks failed", passCount, failCount);
        if (done && failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- threadFetch.sv
/* Thread ring and per-thread program counters
   Rotates the one-hot Q100H thread and muxes its PC to instruction memory */
`timescale 1ns/1ps
`default_nettype none

module threadFetch (
    input  wire logic           QClk,
    input  wire logic           arstN,
    input  gpcPkg::wordT        nextPc,       // From branch unit in Q102H
    input  gpcPkg::threadT      pcEnThread,   // Thread currently in Q102H
    output gpcPkg::wordT        pc,
    output gpcPkg::threadT      thread
);

    gpcPkg::threadT ringQ100H;
    gpcPkg::wordT   pcReg [gpcPkg::NUM_THREADS];

    // Rotate one position per cycle
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            ringQ100H <= gpcPkg::THREAD_RESET;
        end else begin
            ringQ100H <= {ringQ100H[gpcPkg::NUM_THREADS-2:0],
                          ringQ100H[gpcPkg::NUM_THREADS-1]};
        end
    end

    // One PC per thread, loaded when that thread leaves Q102H
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            for (int t = 0; t < gpcPkg::NUM_THREADS; t++) begin
                pcReg[t] <= '0;   // All threads boot at 0
            end
        end else begin
            for (int t = 0; t < gpcPkg::NUM_THREADS; t++) begin
                if (pcEnThread[t]) pcReg[t] <= nextPc;
            end
        end
    end

    // Fetch PC mux on ring
    always_comb begin
        pc = '0;
        for (int t = 0; t < gpcPkg::NUM_THREADS; t++) begin
            if (ringQ100H[t]) pc |= pcReg[t];
        end
    end

    assign thread = ringQ100H;

    // Exactly one thread owns the fetch slot
    ringOneHot: assert property (@(posedge QClk) disable iff (!arstN) $onehot(ringQ100H))
        else $error("thread ring lost one-hot state");

endmodule

`default_nettype wire

//--- writebackStage.sv
/* Q103H and Q104H stage flops
   Drives the data-memory store and selects the register write value */
`timescale 1ns/1ps
`default_nettype none

module writebackStage (
    input  wire logic           QClk,
    input  wire logic           arstN,
    execIf.dst                  exec,
    input  gpcPkg::wordT        aluResult,
    input  gpcPkg::wordT        linkPc,
    wbIf.src                    wb,
    output gpcPkg::wordT        memAdrs,
    output gpcPkg::wordT        memWrData,
    output logic                memWr
);

    gpcPkg::wordT   wrDataQ102H;
    gpcPkg::wordT   wrDataQ103H;
    gpcPkg::regPtrT rdQ103H;
    gpcPkg::threadT threadQ103H;
    logic           regWrQ103H;

    assign wrDataQ102H = exec.jal ? linkPc : aluResult;   // JAL links PC+4

    //////////////////////////////////////////////////////////////////////
    // Q102H to Q103H
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            memWr       <= 1'b0;
            regWrQ103H  <= 1'b0;
            threadQ103H <= '0;
        end else begin
            memWr       <= exec.store;
            regWrQ103H  <= exec.regWr;
            threadQ103H <= exec.thread;
        end
    end

    always_ff @(posedge QClk) begin
        memAdrs     <= aluResult;         // Store address
        memWrData   <= exec.rs2Data;
        wrDataQ103H <= wrDataQ102H;
        rdQ103H     <= exec.inst[10:7];   // rd low bits
    end

    //////////////////////////////////////////////////////////////////////
    // Q103H to Q104H
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            wb.wrEn   <= 1'b0;
            wb.thread <= '0;
        end else begin
            wb.wrEn   <= regWrQ103H;
            wb.thread <= threadQ103H;
        end
    end

    always_ff @(posedge QClk) begin
        wb.ptr  <= rdQ103H;
        wb.data <= wrDataQ103H;
    end

endmodule

`default_nettype wire
